// ==== hw/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W (`SOC_DATA_W / 8)
`define SOC_APB_W 32

// L2 geometry, 8-byte words
`define SOC_DRAM_WORDS 1024
`define SOC_L2_IDX_W 10
`define SOC_L2_OFF_W 3

// Memory map
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN (`SOC_DRAM_WORDS * `SOC_STRB_W)
`define SOC_UART_BASE 32'hC000_0000
`define SOC_UART_LEN 32'h0000_1000
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN 32'h0000_1000

// Control register offsets
`define SOC_CTRL_OFF_W 12
`define SOC_CTRL_EXIT_OFF 12'h000
`define SOC_CTRL_SCRATCH_OFF 12'h008

`endif

// ==== hw/soc_pkg.sv ====
`include "soc_macros.svh"

package soc_pkg;

  ////////////////////////////////////////////////////////////
  // Basic vectors
  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W-1:0]   data_t;
  typedef logic [`SOC_STRB_W-1:0]   strb_t;
  typedef logic [`SOC_APB_W-1:0]    apb_data_t;
  typedef logic [`SOC_L2_IDX_W-1:0] l2_idx_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  ////////////////////////////////////////////////////////////
  // Host bus
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Request as held by the decode stage
  typedef struct packed {
    bus_req_t req;
    target_e  tgt;
  } stage_req_t;

  // Byte lanes of new_w replace old_w where strb is set
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== hw/addr_decode.sv ====
`timescale 1ns/10ps
`include "soc_macros.svh"

module addr_decode (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  soc_pkg::bus_req_t   req_i,
  input  logic                txn_done_i,
  output soc_pkg::stage_req_t stg_o,
  output logic                l2_start_o,
  output logic                uart_start_o,
  output logic                ctrl_start_o,
  output logic                none_start_o
);
  import soc_pkg::*;

  stage_req_t stg_q;
  target_e    tgt_d;
  logic       accept;
  logic       busy_q;
  logic       launch_q;
  logic [3:0] start_q;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & ~busy_q;

  // Region compare on the incoming address
  always_comb begin
    if (in_window(req_i.addr, `SOC_DRAM_BASE, `SOC_DRAM_LEN)) begin
      tgt_d = TGT_L2;
    end else if (in_window(req_i.addr, `SOC_UART_BASE, `SOC_UART_LEN)) begin
      tgt_d = TGT_UART;
    end else if (in_window(req_i.addr, `SOC_CTRL_BASE, `SOC_CTRL_LEN)) begin
      tgt_d = TGT_CTRL;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stg_q <= '{req: req_i, tgt: tgt_d};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      launch_q <= 1'b0;
      start_q  <= '0;
    end else begin
      launch_q <= accept;
      // One-hot start, one cycle wide
      start_q  <= launch_q ? (4'b0001 << stg_q.tgt) : 4'b0000;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (txn_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign stg_o        = stg_q;
  assign l2_start_o   = start_q[TGT_L2];
  assign uart_start_o = start_q[TGT_UART];
  assign ctrl_start_o = start_q[TGT_CTRL];
  assign none_start_o = start_q[TGT_NONE];

endmodule

// ==== hw/l2_mem.sv ====
`timescale 1ns/10ps
`include "soc_macros.svh"

module l2_mem (
  input  logic                clk_i,
  input  logic                start_i,
  input  soc_pkg::stage_req_t stg_i,
  output logic                done_o,
  output soc_pkg::bus_rsp_t   rsp_o
);
  import soc_pkg::*;

  data_t   mem_q [`SOC_DRAM_WORDS];
  data_t   rdata_q;
  logic    done_q;
  l2_idx_t idx;

  // Word index inside the DRAM window
  assign idx = stg_i.req.addr[`SOC_L2_OFF_W +: `SOC_L2_IDX_W];

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      if (stg_i.req.write) begin
        mem_q[idx] <= merge_bytes(mem_q[idx], stg_i.req.wdata, stg_i.req.strb);
        rdata_q    <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // One-cycle latency
  always_ff @(posedge clk_i) begin
    done_q <= start_i;
  end

  assign done_o = done_q;
  assign rsp_o  = '{rdata: rdata_q, err: 1'b0};

endmodule

// ==== hw/apb_bridge.sv ====
`timescale 1ns/10ps

module apb_bridge (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  soc_pkg::stage_req_t stg_i,
  output logic                done_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output logic                uart_psel_o,
  output logic                uart_penable_o,
  output logic                uart_pwrite_o,
  output soc_pkg::addr_t      uart_paddr_o,
  output soc_pkg::apb_data_t  uart_pwdata_o,
  input  soc_pkg::apb_data_t  uart_prdata_i,
  input  logic                uart_pready_i,
  input  logic                uart_pslverr_i
);
  import soc_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE: begin
        if (start_i) begin
          state_d = APB_SETUP;
        end
      end
      APB_SETUP: begin
        state_d = APB_ACCESS;
      end
      APB_ACCESS: begin
        // Wait states until the slave is ready
        if (uart_pready_i) begin
          state_d = APB_IDLE;
        end
      end
      default: begin
        state_d = APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign uart_psel_o    = (state_q != APB_IDLE);
  assign uart_penable_o = (state_q == APB_ACCESS);
  assign uart_pwrite_o  = stg_i.req.write;
  assign uart_paddr_o   = stg_i.req.addr;
  assign uart_pwdata_o  = apb_data_t'(stg_i.req.wdata);

  // Completes in the pready cycle
  assign done_o      = (state_q == APB_ACCESS) && uart_pready_i;
  assign rsp_o.rdata = stg_i.req.write ? '0 : data_t'(uart_prdata_i);
  assign rsp_o.err   = uart_pslverr_i;

endmodule

// ==== hw/ctrl_regs.sv ====
`timescale 1ns/10ps
`include "soc_macros.svh"

module ctrl_regs (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  soc_pkg::stage_req_t stg_i,
  output logic                done_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output soc_pkg::data_t      exit_o
);
  import soc_pkg::*;

  logic [`SOC_CTRL_OFF_W-1:0] offset;
  logic                       hit_exit;
  logic                       hit_scratch;
  data_t                      exit_q;
  data_t                      scratch_q;
  data_t                      rdata_q;
  logic                       err_q;
  logic                       done_q;

  assign offset      = stg_i.req.addr[`SOC_CTRL_OFF_W-1:0];
  assign hit_exit    = (offset == `SOC_CTRL_EXIT_OFF);
  assign hit_scratch = (offset == `SOC_CTRL_SCRATCH_OFF);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q    <= '0;
      scratch_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= start_i;
      if (start_i && stg_i.req.write) begin
        if (hit_exit) begin
          exit_q <= merge_bytes(exit_q, stg_i.req.wdata, stg_i.req.strb);
        end
        if (hit_scratch) begin
          scratch_q <= merge_bytes(scratch_q, stg_i.req.wdata, stg_i.req.strb);
        end
      end
    end
  end

  // Read-back, error on unknown offset
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      err_q   <= ~(hit_exit | hit_scratch);
      rdata_q <= '0;
      if (!stg_i.req.write && hit_exit) begin
        rdata_q <= exit_q;
      end else if (!stg_i.req.write && hit_scratch) begin
        rdata_q <= scratch_q;
      end
    end
  end

  assign done_o = done_q;
  assign rsp_o  = '{rdata: rdata_q, err: err_q};
  assign exit_o = exit_q;

endmodule

// ==== hw/resp_mux.sv ====
`timescale 1ns/10ps

module resp_mux (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  soc_pkg::stage_req_t stg_i,
  input  logic                none_start_i,
  input  logic                l2_done_i,
  input  soc_pkg::bus_rsp_t   l2_rsp_i,
  input  logic                uart_done_i,
  input  soc_pkg::bus_rsp_t   uart_rsp_i,
  input  logic                ctrl_done_i,
  input  soc_pkg::bus_rsp_t   ctrl_rsp_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output soc_pkg::bus_rsp_t   rsp_o,
  output logic                txn_done_o
);
  import soc_pkg::*;

  logic     sel_done;
  bus_rsp_t sel_rsp;
  logic     valid_q;
  bus_rsp_t rsp_q;

  always_comb begin
    sel_done = 1'b0;
    // Unmapped address gets zero data with error
    sel_rsp  = '{rdata: '0, err: 1'b1};
    case (stg_i.tgt)
      TGT_L2: begin
        sel_done = l2_done_i;
        sel_rsp  = l2_rsp_i;
      end
      TGT_UART: begin
        sel_done = uart_done_i;
        sel_rsp  = uart_rsp_i;
      end
      TGT_CTRL: begin
        sel_done = ctrl_done_i;
        sel_rsp  = ctrl_rsp_i;
      end
      TGT_NONE: begin
        sel_done = none_start_i;
      end
      default: begin
        sel_done = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (valid_q && rsp_ready_i) begin
      valid_q <= 1'b0;
    end else if (sel_done) begin
      valid_q <= 1'b1;
    end
  end

  // Held stable while the host stalls
  always_ff @(posedge clk_i) begin
    if (sel_done && !valid_q) begin
      rsp_q <= sel_rsp;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;
  assign txn_done_o  = valid_q & rsp_ready_i;

endmodule

// ==== hw/soc_fabric.sv ====
`timescale 1ns/10ps

module soc_fabric (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  soc_pkg::bus_req_t  req_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output soc_pkg::bus_rsp_t  rsp_o,
  output soc_pkg::data_t     exit_o,
  // UART APB port
  output logic               uart_psel_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output soc_pkg::addr_t     uart_paddr_o,
  output soc_pkg::apb_data_t uart_pwdata_o,
  input  soc_pkg::apb_data_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i
);
  import soc_pkg::*;

  stage_req_t stg;
  logic       l2_start;
  logic       uart_start;
  logic       ctrl_start;
  logic       none_start;
  logic       txn_done;
  logic       l2_done;
  logic       uart_done;
  logic       ctrl_done;
  bus_rsp_t   l2_rsp;
  bus_rsp_t   uart_rsp;
  bus_rsp_t   ctrl_rsp;

  ////////////////////////////////////////////////////////////
  // Request stage
  addr_decode i_addr_decode (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i      ),
    .txn_done_i  (txn_done   ),
    .stg_o       (stg        ),
    .l2_start_o  (l2_start   ),
    .uart_start_o(uart_start ),
    .ctrl_start_o(ctrl_start ),
    .none_start_o(none_start )
  );

  ////////////////////////////////////////////////////////////
  // Targets
  l2_mem i_l2_mem (
    .clk_i  (clk_i   ),
    .start_i(l2_start),
    .stg_i  (stg     ),
    .done_o (l2_done ),
    .rsp_o  (l2_rsp  )
  );

  apb_bridge i_apb_bridge (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .start_i       (uart_start    ),
    .stg_i         (stg           ),
    .done_o        (uart_done     ),
    .rsp_o         (uart_rsp      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i   (clk_i     ),
    .arst_n_i(arst_n_i  ),
    .start_i (ctrl_start),
    .stg_i   (stg       ),
    .done_o  (ctrl_done ),
    .rsp_o   (ctrl_rsp  ),
    .exit_o  (exit_o    )
  );

  ////////////////////////////////////////////////////////////
  // Response stage
  resp_mux i_resp_mux (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .stg_i       (stg        ),
    .none_start_i(none_start ),
    .l2_done_i   (l2_done    ),
    .l2_rsp_i    (l2_rsp     ),
    .uart_done_i (uart_done  ),
    .uart_rsp_i  (uart_rsp   ),
    .ctrl_done_i (ctrl_done  ),
    .ctrl_rsp_i  (ctrl_rsp   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o      ),
    .txn_done_o  (txn_done   )
  );

endmodule

// ==== verif/soc_fabric_tb.sv ====
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_fabric_tb;
  import soc_pkg::*;

  localparam int          RST_CYCLES = 8;
  localparam logic [31:0] SEED       = 32'd30448;

  typedef struct packed {
    bus_req_t  req;
    apb_data_t prdata;
    logic      pslverr;
    bus_rsp_t  exp_rsp;
    data_t     exp_exit;
  } entry_t;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      req_valid_i;
  logic      req_ready_o;
  bus_req_t  req_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i;
  bus_rsp_t  rsp_o;
  data_t     exit_o;
  logic      uart_psel_o;
  logic      uart_penable_o;
  logic      uart_pwrite_o;
  addr_t     uart_paddr_o;
  apb_data_t uart_pwdata_o;
  apb_data_t uart_prdata_i  = '0;
  logic      uart_pready_i  = 1'b0;
  logic      uart_pslverr_i = 1'b0;

  entry_t      tbl[$];
  string       tbl_name[$];
  entry_t      cur;
  string       cur_name;
  int          cycles      = 0;
  int          cycle_limit = 0;
  int          apb_count   = 0;
  logic [2:0]  apb_wait    = 3'd0;
  logic [31:0] apb_rng     = SEED;
  logic [31:0] bp_rng      = SEED;

  soc_fabric i_soc_fabric (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .req_valid_i   (req_valid_i   ),
    .req_ready_o   (req_ready_o   ),
    .req_i         (req_i         ),
    .rsp_valid_o   (rsp_valid_o   ),
    .rsp_ready_i   (rsp_ready_i   ),
    .rsp_o         (rsp_o         ),
    .exit_o        (exit_o        ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected memory word after a strobed write
  function automatic data_t apply_strobe(input data_t old_w, input data_t new_w,
                                         input strb_t strb);
    data_t mask;
    mask = '0;
    for (int i = 0; i < $bits(strb_t); i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      $display("** Error: %s rsp expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
      stop_on_failure();
    end
  endtask

  task automatic check_exit(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("** Error: %s exit_o expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_apb_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("** Error: %s paddr expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_apb_wdata(input string name, input apb_data_t exp,
                                 input apb_data_t act);
    if (act !== exp) begin
      $display("** Error: %s pwdata expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic add_entry(input string name, input logic wr, input addr_t addr,
                           input data_t wdata, input strb_t strb, input apb_data_t prdata,
                           input logic pslverr, input data_t exp_rdata, input logic exp_err,
                           input data_t exp_exit);
    entry_t e;
    e.req      = '{write: wr, addr: addr, wdata: wdata, strb: strb};
    e.prdata   = prdata;
    e.pslverr  = pslverr;
    e.exp_rsp  = '{rdata: exp_rdata, err: exp_err};
    e.exp_exit = exp_exit;
    tbl.push_back(e);
    tbl_name.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  // Argument order is name, write, addr, wdata, strb, prdata, pslverr, rdata, err, exit
  task automatic build_table();
    data_t word_a;
    data_t word_b;
    data_t exit_m;
    data_t scr_m;
    word_a = 64'h0123_4567_89AB_CDEF;
    word_b = '1;
    exit_m = '0;
    // Word a sits on the L2 index that the unmapped 0x0000_1000 would alias to
    add_entry("l2_wr_full_a", 1, 32'h8000_1000, word_a, 8'hFF, '0, 0, '0, 0, exit_m);
    word_a = apply_strobe(word_a, 64'hFEDC_BA98_7654_3210, 8'h5A);
    add_entry("l2_wr_part_a", 1, 32'h8000_1000, 64'hFEDC_BA98_7654_3210, 8'h5A, '0, 0,
              '0, 0, exit_m);
    add_entry("l2_rd_a", 0, 32'h8000_1000, '0, 8'h00, '0, 0, word_a, 0, exit_m);
    add_entry("l2_wr_full_b", 1, 32'h8000_1FF8, word_b, 8'hFF, '0, 0, '0, 0, exit_m);
    word_b = apply_strobe(word_b, 64'h0, 8'h81);
    add_entry("l2_wr_part_b", 1, 32'h8000_1FF8, 64'h0, 8'h81, '0, 0, '0, 0, exit_m);
    add_entry("l2_rd_b", 0, 32'h8000_1FF8, '0, 8'h00, '0, 0, word_b, 0, exit_m);
    // UART over APB
    add_entry("uart_wr", 1, 32'hC000_0010, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 32'h5555_AAAA,
              0, '0, 0, exit_m);
    add_entry("uart_wr_slverr", 1, 32'hC000_0020, 64'h0000_0000_1234_5678, 8'h0F,
              32'h0, 1, '0, 1, exit_m);
    add_entry("uart_rd", 0, 32'hC000_0004, '0, 8'h00, 32'hA5A5_0F0F, 0,
              64'h0000_0000_A5A5_0F0F, 0, exit_m);
    add_entry("uart_rd_top", 0, 32'hC000_0FFC, '0, 8'h00, 32'h8000_0001, 0,
              64'h0000_0000_8000_0001, 0, exit_m);
    // Control registers
    exit_m = 64'h1122_3344_5566_7788;
    add_entry("ctrl_exit_wr", 1, 32'hD000_0000, exit_m, 8'hFF, '0, 0, '0, 0, exit_m);
    add_entry("ctrl_exit_rd", 0, 32'hD000_0000, '0, 8'h00, '0, 0, exit_m, 0, exit_m);
    exit_m = apply_strobe(exit_m, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0C);
    add_entry("ctrl_exit_part", 1, 32'hD000_0000, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0C, '0, 0,
              '0, 0, exit_m);
    add_entry("ctrl_exit_rd2", 0, 32'hD000_0000, '0, 8'h00, '0, 0, exit_m, 0, exit_m);
    scr_m = apply_strobe('0, 64'hCAFE_F00D_0BAD_BEEF, 8'hF0);
    add_entry("ctrl_scr_wr", 1, 32'hD000_0008, 64'hCAFE_F00D_0BAD_BEEF, 8'hF0, '0, 0,
              '0, 0, exit_m);
    add_entry("ctrl_scr_rd", 0, 32'hD000_0008, '0, 8'h00, '0, 0, scr_m, 0, exit_m);
    add_entry("ctrl_bad_wr", 1, 32'hD000_0010, '1, 8'hFF, '0, 0, '0, 1, exit_m);
    add_entry("ctrl_bad_rd", 0, 32'hD000_0010, '0, 8'h00, '0, 0, '0, 1, exit_m);
    add_entry("ctrl_scr_rd_again", 0, 32'hD000_0008, '0, 8'h00, '0, 0, scr_m, 0, exit_m);
    // Outside the map
    add_entry("none_wr", 1, 32'h0000_1000, '1, 8'hFF, '0, 0, '0, 1, exit_m);
    add_entry("none_rd", 0, 32'h0000_1000, '0, 8'h00, '0, 0, '0, 1, exit_m);
    add_entry("none_past_l2", 0, 32'h8000_2000, '0, 8'h00, '0, 0, '0, 1, exit_m);
    add_entry("l2_rd_a_again", 0, 32'h8000_1000, '0, 8'h00, '0, 0, word_a, 0, exit_m);
    add_entry("l2_rd_b_again", 0, 32'h8000_1FF8, '0, 8'h00, '0, 0, word_b, 0, exit_m);
  endtask

  ////////////////////////////////////////////////////////////
  // APB slave model

  always @(posedge clk_i) begin
    if (uart_psel_o && !uart_penable_o) begin
      apb_count <= apb_count + 1;
      check_apb_addr(cur_name, cur.req.addr, uart_paddr_o);
      if (uart_pwrite_o !== cur.req.write) begin
        $display("** Error: %s pwrite expected %b actual %b",
                 cur_name, cur.req.write, uart_pwrite_o);
        stop_on_failure();
      end
      if (cur.req.write) begin
        check_apb_wdata(cur_name, cur.req.wdata[31:0], uart_pwdata_o);
      end
      apb_rng = xorshift32(apb_rng);
      apb_wait       <= apb_rng[2:0];
      uart_pready_i  <= (apb_rng[2:0] == 3'd0);
      uart_prdata_i  <= cur.prdata;
      uart_pslverr_i <= cur.pslverr;
    end else if (uart_psel_o && uart_penable_o) begin
      if (uart_pready_i) begin
        uart_pready_i <= 1'b0;
      end else begin
        apb_wait <= apb_wait - 3'd1;
        if (apb_wait == 3'd1) begin
          uart_pready_i <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      stop_on_failure();
    end
  end

  ////////////////////////////////////////////////////////////
  // One table entry from request to response

  task automatic run_entry(input int idx);
    bus_rsp_t held;
    int       apb_before;
    logic     expect_apb;
    cur        = tbl[idx];
    cur_name   = tbl_name[idx];
    apb_before = apb_count;
    expect_apb = (cur.req.addr >= `SOC_UART_BASE) &&
                 (cur.req.addr < (`SOC_UART_BASE + `SOC_UART_LEN));
    req_valid_i <= 1'b1;
    req_i       <= cur.req;
    do begin
      @(posedge clk_i);
    end while (!req_ready_o);
    req_valid_i <= 1'b0;
    req_i       <= '0;
    // No new request while the transaction is open
    do begin
      @(posedge clk_i);
      if (req_ready_o) begin
        $display("%s: req_ready_o went high before the response", cur_name);
        stop_on_failure();
      end
    end while (!rsp_valid_o);
    held   = rsp_o;
    bp_rng = xorshift32(bp_rng);
    repeat (bp_rng[2:0]) begin
      @(posedge clk_i);
      if (!rsp_valid_o || req_ready_o) begin
        $display("%s: response dropped or request port reopened under stall", cur_name);
        stop_on_failure();
      end
      check_rsp(cur_name, held, rsp_o);
    end
    rsp_ready_i <= 1'b1;
    @(posedge clk_i);
    if (!rsp_valid_o) begin
      $display("%s: rsp_valid_o low on the transfer edge", cur_name);
      stop_on_failure();
    end
    check_rsp(cur_name, held, rsp_o);
    rsp_ready_i <= 1'b0;
    check_rsp(cur_name, cur.exp_rsp, held);
    check_exit(cur_name, cur.exp_exit, exit_o);
    if ((apb_count - apb_before) != (expect_apb ? 1 : 0)) begin
      $display("%s: wrong number of APB transfers, saw %0d", cur_name,
               apb_count - apb_before);
      stop_on_failure();
    end
  endtask

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    build_table();
    cycle_limit = tbl.size() * 30 + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    if (!req_ready_o || rsp_valid_o || uart_psel_o || uart_penable_o) begin
      $display("Outputs not in their reset state after reset");
      stop_on_failure();
    end
    check_exit("reset", '0, exit_o);
    for (int i = 0; i < tbl.size(); i++) begin
      run_entry(i);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== soc_fabric.f ====
+incdir+hw
hw/soc_pkg.sv
hw/addr_decode.sv
hw/l2_mem.sv
hw/apb_bridge.sv
hw/ctrl_regs.sv
hw/resp_mux.sv
hw/soc_fabric.sv
verif/soc_fabric_tb.sv

// ==== Makefile ====
TOP := soc_fabric_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f soc_fabric.f --top-module soc_fabric
	verilator --lint-only --timing -f soc_fabric.f --top-module $(TOP)

sim:
	verilator --binary --timing -f soc_fabric.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
